// File: bench/tb_mem_1r4w.sv
// random writes stay in an 8-word window at 0x40 so ports collide; bp_thr is fixed at depth-8.
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module tb_mem_1r4w;

  localparam int CLK_PERIOD  = 20;
  localparam int RST_CYCLES  = 2;
  localparam int INIT_CYCLES = `MEM_NUMADDR;
  localparam int SCAN_CYCLES = `MEM_NUMADDR + 1;
  localparam int RAND_CYCLES = 500;
  localparam int FWD_CYCLES  = 13;
  localparam int FLOOD_LIMIT = 30;
  localparam int DRAIN_LIMIT = 30;
  localparam int RUN_CYCLES  = RST_CYCLES + INIT_CYCLES + 2 + SCAN_CYCLES + RAND_CYCLES +
                               FWD_CYCLES + FLOOD_LIMIT + DRAIN_LIMIT + 100;
  localparam mem_pkg::addr_t WIN_BASE = 8'h40;

  logic                                clk;
  logic                                arst_n;
  logic [`MEM_NUMWRPT-1:0]             write;
  mem_pkg::addr_t [`MEM_NUMWRPT-1:0]   wr_adr;
  mem_pkg::data_t [`MEM_NUMWRPT-1:0]   din;
  mem_pkg::fcnt_t                      bp_thr;
  logic [`MEM_NUMWRPT-1:0]             wr_bp;
  logic                                read;
  mem_pkg::addr_t                      rd_adr;
  logic                                rd_vld;
  mem_pkg::data_t                      rd_dout;
  logic                                ready;

  mem_pkg::data_t ref_mem [`MEM_NUMADDR];
  logic           exp_vld = 1'b0;
  mem_pkg::data_t exp_data;
  mem_pkg::addr_t exp_adr;
  logic           bp_seen = 1'b1;
  logic [31:0]    rng_state;
  int             model_count;
  int             bp_errors;
  int             ovf_errors;
  int             data_errors = 0;
  int             misc_errors = 0;

  mem_1r4w_top uut (
    .clk (clk), .arst_n (arst_n), .write (write), .wr_adr (wr_adr), .din (din),
    .bp_thr (bp_thr), .wr_bp (wr_bp), .read (read), .rd_adr (rd_adr),
    .rd_vld (rd_vld), .rd_dout (rd_dout), .ready (ready)
  );

  wrfifo_checker chk (
    .clk (clk), .arst_n (arst_n), .write (write), .ready (ready), .bp_thr (bp_thr),
    .wr_bp (wr_bp), .model_count (model_count), .bp_errors (bp_errors),
    .ovf_errors (ovf_errors)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic mem_pkg::addr_t window_adr();
    logic [31:0] r;
    r = next_rand();
    return WIN_BASE + mem_pkg::addr_t'(r[31:29]); // upper bits, the low ones cycle.
  endfunction

  task automatic drive_inputs(input logic [`MEM_NUMWRPT-1:0] mask,
                              input mem_pkg::addr_t [`MEM_NUMWRPT-1:0] adrs,
                              input mem_pkg::data_t [`MEM_NUMWRPT-1:0] dat,
                              input logic rd, input mem_pkg::addr_t radr);
    write  <= mask;
    wr_adr <= adrs;
    din    <= dat;
    read   <= rd;
    rd_adr <= radr;
  endtask

  task automatic drive_idle();
    write <= '0;
    read  <= 1'b0;
  endtask

  task automatic drive_random(input logic allow_wr);
    logic [31:0]                        r;
    mem_pkg::addr_t [`MEM_NUMWRPT-1:0]  adrs;
    mem_pkg::data_t [`MEM_NUMWRPT-1:0]  dat;
    r = next_rand();
    for (int i = 0; i < `MEM_NUMWRPT; i++) begin
      adrs[i] = (r[25] && i > 0) ? adrs[0] : window_adr(); // sometimes one address on all ports.
      dat[i]  = next_rand();
    end
    drive_inputs(allow_wr ? r[31:28] : '0, adrs, dat, r[27], window_adr());
  endtask

  // writes offered during init must be dropped.
  task automatic check_init();
    for (int n = 1; n <= INIT_CYCLES + 2; n++) begin
      @(posedge clk);
      if (n < INIT_CYCLES - 4) begin
        drive_random(1'b1);
      end else begin
        drive_idle();
      end
      @(negedge clk);
      assert (ready == (n >= INIT_CYCLES)) else begin
        misc_errors++;
        $display("CHECK FAILED ready: got %h expected %h at edge %0d", ready,
                 n >= INIT_CYCLES, n);
      end
    end
  endtask

  task automatic scan_unwritten();
    for (int a = 0; a < `MEM_NUMADDR; a++) begin
      @(posedge clk);
      drive_inputs('0, wr_adr, din, 1'b1, mem_pkg::addr_t'(a));
    end
    @(posedge clk);
    drive_idle();
  endtask

  task automatic forward_sequence();
    mem_pkg::addr_t                     a;
    mem_pkg::addr_t [`MEM_NUMWRPT-1:0]  adrs;
    mem_pkg::data_t [`MEM_NUMWRPT-1:0]  dat;
    a = window_adr();
    repeat (8) begin
      @(posedge clk);
      drive_idle();
    end
    for (int i = 0; i < `MEM_NUMWRPT; i++) begin
      adrs[i] = a;
      dat[i]  = next_rand();
    end
    @(posedge clk);
    drive_inputs('1, adrs, dat, 1'b0, a);
    adrs[0] = a + mem_pkg::addr_t'(1);
    dat[0]  = next_rand();
    dat[2]  = next_rand();
    @(posedge clk);
    drive_inputs(4'b0101, adrs, dat, 1'b1, a); // four pending entries for a.
    @(posedge clk);
    drive_inputs('0, adrs, dat, 1'b1, a);
    @(posedge clk);
    drive_inputs('0, adrs, dat, 1'b1, adrs[0]);
    @(posedge clk);
    drive_idle();
  endtask

  task automatic flood_and_drain();
    mem_pkg::addr_t [`MEM_NUMWRPT-1:0]  adrs;
    mem_pkg::data_t [`MEM_NUMWRPT-1:0]  dat;
    logic                               rose;
    logic                               fell;
    rose = 1'b0;
    fell = 1'b0;
    for (int n = 0; n < FLOOD_LIMIT && !rose; n++) begin
      @(posedge clk);
      if (bp_seen) begin
        rose = 1'b1;
        drive_idle();
      end else begin
        for (int i = 0; i < `MEM_NUMWRPT; i++) begin
          adrs[i] = window_adr();
          dat[i]  = next_rand();
        end
        drive_inputs('1, adrs, dat, 1'b1, window_adr());
      end
    end
    if (!rose) begin
      misc_errors++;
      $display("wr_bp never rose while all four ports kept writing");
    end
    for (int n = 0; n < DRAIN_LIMIT && !fell; n++) begin
      @(posedge clk);
      drive_random(1'b0);
      fell = !bp_seen;
    end
    if (!fell) begin
      misc_errors++;
      $display("wr_bp stayed high after the writes stopped");
    end else begin
      @(negedge clk);
      assert (model_count <= int'(bp_thr)) else begin
        misc_errors++;
        $display("CHECK FAILED model_count: got %h expected at most %h", model_count, bp_thr);
      end
    end
  endtask

  // reference memory and expected read, sampled as the DUT sees the edge.
  always @(posedge clk) begin
    if (!arst_n) begin
      exp_vld <= 1'b0;
      for (int i = 0; i < `MEM_NUMADDR; i++) begin
        ref_mem[i] = '0;
      end
    end else begin
      exp_vld  <= read & ready;
      exp_data <= ref_mem[rd_adr];
      exp_adr  <= rd_adr;
      for (int i = 0; i < `MEM_NUMWRPT; i++) begin
        if (ready && write[i]) begin
          ref_mem[wr_adr[i]] = din[i]; // higher port lands last.
        end
      end
    end
  end

  always @(negedge clk) begin
    bp_seen <= wr_bp[0];
    if (arst_n) begin
      assert (rd_vld == exp_vld) else begin
        data_errors++;
        $display("CHECK FAILED rd_vld: got %h expected %h", rd_vld, exp_vld);
      end
      if (exp_vld) begin
        assert (rd_dout == exp_data) else begin
          data_errors++;
          $display("CHECK FAILED rd_dout: got %h expected %h at address %h", rd_dout,
                   exp_data, exp_adr);
        end
      end
    end
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles before the tests ended", RUN_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int total;
    rng_state = 32'd15;
    arst_n    = 1'b0;
    write     = '0;
    wr_adr    = '0;
    din       = '0;
    read      = 1'b0;
    rd_adr    = '0;
    bp_thr    = mem_pkg::fcnt_t'(`MEM_FIFO_DEPTH - 8);
    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    check_init();
    scan_unwritten();
    for (int n = 0; n < RAND_CYCLES; n++) begin
      @(posedge clk);
      drive_random(!bp_seen);
    end
    forward_sequence();
    flood_and_drain();
    repeat (3) begin
      @(posedge clk);
      drive_idle();
    end
    @(negedge clk);
    total = data_errors + misc_errors + bp_errors + ovf_errors;
    $display("errors: read data %0d, init and flow %0d, wr_bp %0d, overflow %0d",
             data_errors, misc_errors, bp_errors, ovf_errors);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/wrfifo_checker.sv
// write fifo count model from top-level ports only; bp_thr must stay static during a run.
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module wrfifo_checker (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire [`MEM_NUMWRPT-1:0]  write,
  input  wire                     ready,
  input  mem_pkg::fcnt_t          bp_thr,
  input  wire [`MEM_NUMWRPT-1:0]  wr_bp,
  output int                      model_count,
  output int                      bp_errors,
  output int                      ovf_errors
);

  logic                    bp_exp;
  logic [`MEM_NUMWRPT-1:0] bp_want;

  // writes only count while ready is high.
  function automatic int accepted(input logic [`MEM_NUMWRPT-1:0] w, input logic rdy);
    int n;
    n = 0;
    for (int i = 0; i < `MEM_NUMWRPT; i++) begin
      if (w[i] && rdy) begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic int pops(input int cnt);
    return (cnt < `MEM_NUMDRAIN) ? cnt : `MEM_NUMDRAIN;
  endfunction

  initial begin
    bp_errors  = 0;
    ovf_errors = 0;
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      model_count <= 0;
      bp_exp      <= 1'b1;
    end else begin
      bp_exp      <= (model_count > int'(bp_thr)); // previous count.
      model_count <= model_count + accepted(write, ready) - pops(model_count);
    end
  end

  // outputs are settled by the falling edge.
  always @(negedge clk) begin
    if (arst_n) begin
      bp_want = {`MEM_NUMWRPT{bp_exp | ~ready}};
      assert (wr_bp == bp_want) else begin
        bp_errors++;
        $display("CHECK FAILED wr_bp: got %h expected %h", wr_bp, bp_want);
      end
      assert (model_count <= `MEM_FIFO_DEPTH) else begin
        ovf_errors++;
        $display("write fifo overflow, modeled count %0d is above the depth", model_count);
      end
    end
  end

endmodule

`default_nettype wire

// File: design/bank_array.sv
// flop array with no reset; contents are undefined until the init sequencer has cleared it.
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module bank_array (
  input  wire                                 clk,
  input  wire                                 clr_en,
  input  mem_pkg::addr_t                      clr_adr,
  input  wire  [`MEM_NUMDRAIN-1:0]            drn_en,
  input  mem_pkg::addr_t [`MEM_NUMDRAIN-1:0]  drn_adr,
  input  mem_pkg::data_t [`MEM_NUMDRAIN-1:0]  drn_data,
  input  mem_pkg::addr_t                      rd_adr,
  output mem_pkg::data_t                      arr_data
);

  mem_pkg::data_t mem [`MEM_NUMADDR];

  // clear only runs before ready, drains only after.
  always_ff @(posedge clk) begin
    if (clr_en) begin
      mem[clr_adr] <= '0;
    end
    for (int k = 0; k < `MEM_NUMDRAIN; k++) begin
      // higher drain port is younger, last assignment wins.
      if (drn_en[k]) begin
        mem[drn_adr[k]] <= drn_data[k];
      end
    end
  end

  // registered read, old data on a same-edge drain.
  always_ff @(posedge clk) begin
    arr_data <= mem[rd_adr];
  end

endmodule

`default_nettype wire

// File: design/init_seq.sv
// clears one row per clock after reset; ready stays low for MEM_NUMADDR cycles.
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module init_seq (
  input  wire             clk,
  input  wire             arst_n,
  output logic            clr_en,
  output mem_pkg::addr_t  clr_adr,
  output logic            ready
);

  mem_pkg::init_state_e state;
  mem_pkg::addr_t       row;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= mem_pkg::INIT_CLEAR;
      row   <= '0;
    end else begin
      case (state)
        mem_pkg::INIT_CLEAR: begin
          row <= row + 1'b1; // wraps back to zero on the last row.
          if (row == mem_pkg::addr_t'(`MEM_NUMADDR - 1)) begin
            state <= mem_pkg::INIT_DONE;
          end
        end
        default: begin
          state <= mem_pkg::INIT_DONE; // hold until the next reset.
        end
      endcase
    end
  end

  assign clr_en  = (state == mem_pkg::INIT_CLEAR);
  assign clr_adr = row;
  assign ready   = (state == mem_pkg::INIT_DONE);

endmodule

`default_nettype wire

// File: design/mem_1r4w_top.sv
// 1r4w memory top; writes are dropped while ready is low and must stop while wr_bp is high.
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module mem_1r4w_top (
  input  wire                                 clk,
  input  wire                                 arst_n,
  input  wire  [`MEM_NUMWRPT-1:0]             write,
  input  mem_pkg::addr_t [`MEM_NUMWRPT-1:0]   wr_adr,
  input  mem_pkg::data_t [`MEM_NUMWRPT-1:0]   din,
  input  mem_pkg::fcnt_t                      bp_thr,
  output logic [`MEM_NUMWRPT-1:0]             wr_bp,
  input  wire                                 read,
  input  mem_pkg::addr_t                      rd_adr,
  output logic                                rd_vld,
  output mem_pkg::data_t                      rd_dout,
  output logic                                ready
);

  // init clear port.
  logic                               clr_en;
  mem_pkg::addr_t                     clr_adr;

  // fifo drain into the array.
  logic [`MEM_NUMDRAIN-1:0]           drn_en;
  mem_pkg::addr_t [`MEM_NUMDRAIN-1:0] drn_adr;
  mem_pkg::data_t [`MEM_NUMDRAIN-1:0] drn_data;

  // read path.
  logic                               fwd_hit;
  mem_pkg::data_t                     fwd_data;
  mem_pkg::data_t                     arr_data;

  init_seq u_init (
    .clk     (clk),
    .arst_n  (arst_n),
    .clr_en  (clr_en),
    .clr_adr (clr_adr),
    .ready   (ready)
  );

  write_fifo u_fifo (
    .clk      (clk),
    .arst_n   (arst_n),
    .ready    (ready),
    .write    (write),
    .wr_adr   (wr_adr),
    .din      (din),
    .bp_thr   (bp_thr),
    .rd_adr   (rd_adr),
    .wr_bp    (wr_bp),
    .drn_en   (drn_en),
    .drn_adr  (drn_adr),
    .drn_data (drn_data),
    .fwd_hit  (fwd_hit),
    .fwd_data (fwd_data)
  );

  bank_array u_array (
    .clk      (clk),
    .clr_en   (clr_en),
    .clr_adr  (clr_adr),
    .drn_en   (drn_en),
    .drn_adr  (drn_adr),
    .drn_data (drn_data),
    .rd_adr   (rd_adr),
    .arr_data (arr_data)
  );

  read_port u_read (
    .clk      (clk),
    .arst_n   (arst_n),
    .ready    (ready),
    .read     (read),
    .fwd_hit  (fwd_hit),
    .fwd_data (fwd_data),
    .arr_data (arr_data),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout)
  );

endmodule

`default_nettype wire

// File: design/mem_pkg.sv
// shared types; widths follow mem_defs.svh, which must be on the include path.
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

  // one data word.
  typedef logic [`MEM_WIDTH-1:0] data_t;

  // one word address.
  typedef logic [`MEM_BITADDR-1:0] addr_t;

  // fifo occupancy, one extra bit so a full fifo is representable.
  typedef logic [`MEM_BITFIFO:0] fcnt_t;

  // init sequencer states.
  typedef enum logic [0:0] {
    INIT_CLEAR,
    INIT_DONE
  } init_state_e;

endpackage

`default_nettype wire

// File: design/read_port.sv
// read data is valid one cycle after read; reads before ready return rd_vld low.
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module read_port (
  input  wire             clk,
  input  wire             arst_n,
  input  wire             ready,
  input  wire             read,
  input  wire             fwd_hit,
  input  mem_pkg::data_t  fwd_data,
  input  mem_pkg::data_t  arr_data,
  output logic            rd_vld,
  output mem_pkg::data_t  rd_dout
);

  logic           fwd_hit_q;
  mem_pkg::data_t fwd_data_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_vld    <= 1'b0;
      fwd_hit_q <= 1'b0;
    end else begin
      rd_vld    <= read & ready;
      fwd_hit_q <= fwd_hit;
    end
  end

  always_ff @(posedge clk) begin
    fwd_data_q <= fwd_data; // captured alongside arr_data.
  end

  // pending fifo data beats the array.
  assign rd_dout = fwd_hit_q ? fwd_data_q : arr_data;

endmodule

`default_nettype wire

// File: design/write_fifo.sv
// shared write fifo; pushes beyond the depth overwrite old entries, so users must obey wr_bp.
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module write_fifo (
  input  wire                                     clk,
  input  wire                                     arst_n,
  input  wire                                     ready,
  input  wire  [`MEM_NUMWRPT-1:0]                 write,
  input  mem_pkg::addr_t [`MEM_NUMWRPT-1:0]       wr_adr,
  input  mem_pkg::data_t [`MEM_NUMWRPT-1:0]       din,
  input  mem_pkg::fcnt_t                          bp_thr,
  input  mem_pkg::addr_t                          rd_adr,
  output logic [`MEM_NUMWRPT-1:0]                 wr_bp,
  output logic [`MEM_NUMDRAIN-1:0]                drn_en,
  output mem_pkg::addr_t [`MEM_NUMDRAIN-1:0]      drn_adr,
  output mem_pkg::data_t [`MEM_NUMDRAIN-1:0]      drn_data,
  output logic                                    fwd_hit,
  output mem_pkg::data_t                          fwd_data
);

  localparam int DEPTH = `MEM_FIFO_DEPTH;

  typedef logic [`MEM_BITFIFO-1:0] ptr_t;

  // entry storage, no reset.
  mem_pkg::addr_t ent_adr [DEPTH];
  mem_pkg::data_t ent_dat [DEPTH];

  ptr_t            wr_ptr;
  ptr_t            rd_ptr;
  mem_pkg::fcnt_t  count;
  mem_pkg::fcnt_t  count_nxt;
  mem_pkg::fcnt_t  push_num;
  mem_pkg::fcnt_t  pop_num;
  logic [`MEM_NUMWRPT-1:0] push;
  ptr_t            push_slot [`MEM_NUMWRPT];
  logic            bp_q;

  // accepted writes are packed in ascending port order.
  always_comb begin
    push     = write & {`MEM_NUMWRPT{ready}};
    push_num = '0;
    for (int i = 0; i < `MEM_NUMWRPT; i++) begin
      push_slot[i] = wr_ptr + ptr_t'(push_num);
      push_num     = push_num + mem_pkg::fcnt_t'(push[i]);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `MEM_NUMWRPT; i++) begin
      if (push[i]) begin
        ent_adr[push_slot[i]] <= wr_adr[i];
        ent_dat[push_slot[i]] <= din[i];
      end
    end
  end

  // drain the oldest entries, at most MEM_NUMDRAIN per cycle.
  always_comb begin
    if (count > mem_pkg::fcnt_t'(`MEM_NUMDRAIN)) begin
      pop_num = mem_pkg::fcnt_t'(`MEM_NUMDRAIN);
    end else begin
      pop_num = count;
    end
    for (int k = 0; k < `MEM_NUMDRAIN; k++) begin
      drn_en[k]   = mem_pkg::fcnt_t'(k) < pop_num; // port 1 is the younger entry.
      drn_adr[k]  = ent_adr[rd_ptr + ptr_t'(k)];
      drn_data[k] = ent_dat[rd_ptr + ptr_t'(k)];
    end
  end

  assign count_nxt = count + push_num - pop_num;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      bp_q   <= 1'b1;
    end else begin
      wr_ptr <= wr_ptr + ptr_t'(push_num);
      rd_ptr <= rd_ptr + ptr_t'(pop_num);
      count  <= count_nxt;
      bp_q   <= (count > bp_thr); // one cycle behind the count.
    end
  end

  // held high until init is done.
  assign wr_bp = {`MEM_NUMWRPT{bp_q | ~ready}};

  // forwarding lookup over valid entries, oldest to newest.
  always_comb begin
    fwd_hit  = 1'b0;
    fwd_data = '0;
    for (int k = 0; k < DEPTH; k++) begin
      if ((mem_pkg::fcnt_t'(k) < count) &&
          (ent_adr[rd_ptr + ptr_t'(k)] == rd_adr)) begin
        // a later match is newer and overrides.
        fwd_hit  = 1'b1;
        fwd_data = ent_dat[rd_ptr + ptr_t'(k)];
      end
    end
  end

endmodule

`default_nettype wire

// File: include/mem_defs.svh
// sizes for the 1r4w memory; fifo depth must stay a power of two and exceed 2*MEM_NUMWRPT.
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data word and address space.
`define MEM_WIDTH      32
`define MEM_BITADDR    8
`define MEM_NUMADDR    256

// port counts.
`define MEM_NUMWRPT    4
`define MEM_NUMDRAIN   2

// write fifo, depth is 2**MEM_BITFIFO.
`define MEM_BITFIFO    4
`define MEM_FIFO_DEPTH 16

`endif

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
  --top-module tb_mem_1r4w -f tb.f -o sim_mem_1r4w &&
./obj_dir/sim_mem_1r4w | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb.f
+incdir+include
design/mem_pkg.sv
design/init_seq.sv
design/write_fifo.sv
design/bank_array.sv
design/read_port.sv
design/mem_1r4w_top.sv
bench/wrfifo_checker.sv
bench/tb_mem_1r4w.sv
